/* verilog/cardinal_pkg.sv */
package cardinal_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------
	localparam int XLEN   = 64;    // data word
	localparam int ILEN   = 32;    // instruction and pc
	localparam int NREG   = 32;
	localparam int REG_AW = 5;
	localparam int IMM_W  = 16;    // memory immediate

	localparam logic [0:ILEN-1] PC_STEP = 32'd4;

	// ------------------------------------------------------------------------
	// field types, bit 0 is the leftmost bit
	// ------------------------------------------------------------------------
	typedef logic [0:XLEN-1]   word_t;
	typedef logic [0:REG_AW-1] reg_addr_t;
	typedef logic [0:1]        width_t;    // ww, lane width 8 << ww
	typedef logic [0:2]        ppp_t;
	typedef logic [0:5]        opcode_t;
	typedef logic [0:5]        func_t;
	typedef logic [0:IMM_W-1]  imm_t;

	// opcodes
	localparam opcode_t OP_ALU   = 6'b101010;
	localparam opcode_t OP_LOAD  = 6'b100000;
	localparam opcode_t OP_STORE = 6'b100001;
	localparam opcode_t OP_NOP   = 6'b111100;

	// alu function codes
	localparam func_t FN_AND  = 6'd0;
	localparam func_t FN_OR   = 6'd1;
	localparam func_t FN_XOR  = 6'd2;
	localparam func_t FN_NOT  = 6'd3;
	localparam func_t FN_MOV  = 6'd4;
	localparam func_t FN_ADD  = 6'd5;
	localparam func_t FN_SUB  = 6'd6;
	localparam func_t FN_SWAP = 6'd9;
	localparam func_t FN_SLL  = 6'd10;
	localparam func_t FN_SRL  = 6'd12;
	localparam func_t FN_SRA  = 6'd14;

	// participation
	localparam ppp_t PPP_ALL = 3'b000;    // whole word
	localparam ppp_t PPP_HI  = 3'b001;    // bits 0..31
	localparam ppp_t PPP_LO  = 3'b010;    // bits 32..63

	// ------------------------------------------------------------------------
	// pipeline structs
	// ------------------------------------------------------------------------
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t rd;
		reg_addr_t ra;     // also the store source
		reg_addr_t rb;
		ppp_t      ppp;
		width_t    ww;
		func_t     func;
		imm_t      imm;
	} dec_t;

	typedef struct packed {
		logic      we;
		reg_addr_t rd;
		ppp_t      ppp;
		word_t     data;
	} wb_t;

endpackage

/* verilog/simd_alu.sv */
module simd_alu import cardinal_pkg::*; (
	input  func_t  i_func,
	input  width_t i_ww,
	input  word_t  i_a,
	input  word_t  i_b,
	output word_t  o_y
);

	localparam int NW = 4;    // 8, 16, 32, 64 bit lanes

	// one lane-wise result per possible width, picked by ww
	word_t lane_res [NW];

	// ------------------------------------------------------------------------
	// lane datapaths
	// ------------------------------------------------------------------------
	for (genvar w = 0; w < NW; w++) begin : g_width
		localparam int W  = 8 << w;
		localparam int SW = $clog2(W);

		for (genvar k = 0; k < XLEN / W; k++) begin : g_lane
			logic [W-1:0]  a;
			logic [W-1:0]  b;
			logic [W-1:0]  y;
			logic [SW-1:0] sh;

			assign a  = i_a[k*W +: W];    // lane k counted from the left
			assign b  = i_b[k*W +: W];
			assign sh = b[SW-1:0];        // low log2(W) bits of the rB lane

			always_comb begin
				case (i_func)
					FN_ADD:  y = a + b;    // carry dropped at lane edge
					FN_SUB:  y = a - b;
					FN_SWAP: y = {a[W/2-1:0], a[W-1:W/2]};
					FN_SLL:  y = a << sh;
					FN_SRL:  y = a >> sh;
					FN_SRA:  y = $signed(a) >>> sh;    // fills with lane msb
					default: y = '0;
				endcase
			end

			assign lane_res[w][k*W +: W] = y;
		end
	end

	// ------------------------------------------------------------------------
	// result select
	// ------------------------------------------------------------------------
	always_comb begin
		case (i_func)
			FN_AND:  o_y = i_a & i_b;
			FN_OR:   o_y = i_a | i_b;
			FN_XOR:  o_y = i_a ^ i_b;
			FN_NOT:  o_y = ~i_a;
			FN_MOV:  o_y = i_a;
			FN_ADD,
			FN_SUB,
			FN_SWAP,
			FN_SLL,
			FN_SRL,
			FN_SRA:  o_y = lane_res[i_ww];
			default: o_y = '0;    // mul and immediate shifts not supported
		endcase
	end

endmodule

/* verilog/fetch_decode.sv */
module fetch_decode import cardinal_pkg::*; (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic [0:ILEN-1] i_instruction,
	output logic [0:ILEN-1] o_pc,
	output dec_t            o_dec
);

	// alu format: op | rD | rA | rB | ppp | ww | func
	typedef struct packed {
		opcode_t   op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		ppp_t      ppp;
		width_t    ww;
		func_t     func;
	} r_fmt_t;

	// load/store format: op | reg | unused | imm
	typedef struct packed {
		opcode_t   op;
		reg_addr_t r;
		reg_addr_t pad;
		imm_t      imm;
	} m_fmt_t;

	logic [0:ILEN-1] pc_q;
	logic [0:ILEN-1] ir_q;
	r_fmt_t          r_word;
	m_fmt_t          m_word;

	// ------------------------------------------------------------------------
	// program counter and instruction register
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pc_q <= '0;
			ir_q <= '0;    // opcode 0 decodes as nop
		end else begin
			pc_q <= pc_q + PC_STEP;
			ir_q <= i_instruction;
		end
	end

	assign o_pc = pc_q;

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	assign r_word = ir_q;
	assign m_word = ir_q;

	always_comb begin
		o_dec = '0;
		o_dec.opcode = OP_NOP;    // unknown opcodes fall through as nop
		case (r_word.op)
			OP_ALU: begin
				o_dec.opcode = OP_ALU;
				o_dec.rd     = r_word.rd;
				o_dec.ra     = r_word.ra;
				o_dec.rb     = r_word.rb;
				o_dec.ppp    = r_word.ppp;
				o_dec.ww     = r_word.ww;
				o_dec.func   = r_word.func;
			end
			OP_LOAD: begin
				o_dec.opcode = OP_LOAD;
				o_dec.rd     = m_word.r;    // load target
				o_dec.imm    = m_word.imm;
			end
			OP_STORE: begin
				o_dec.opcode = OP_STORE;
				o_dec.ra     = m_word.r;    // store data comes out of rA port
				o_dec.imm    = m_word.imm;
			end
			default: begin
			end
		endcase
	end

endmodule

/* verilog/reg_file.sv */
module reg_file import cardinal_pkg::*; (
	input  logic      CLK,
	input  logic      RST,
	input  reg_addr_t i_ra,
	input  reg_addr_t i_rb,
	input  wb_t       i_wb,
	output word_t     o_rs1,
	output word_t     o_rs2
);

	localparam int HALF = XLEN / 2;

	word_t rf_mem [NREG];
	logic  wr_ok;

	// asynchronous reads, no bypass of a same-cycle write
	assign o_rs1 = rf_mem[i_ra];
	assign o_rs2 = rf_mem[i_rb];

	assign wr_ok = i_wb.we && (i_wb.rd != '0);    // r0 stays zero

	// ------------------------------------------------------------------------
	// masked write
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			for (int i = 0; i < NREG; i++) begin
				rf_mem[i] <= '0;
			end
		end else if (wr_ok) begin
			case (i_wb.ppp)
				PPP_HI: begin
					rf_mem[i_wb.rd][0:HALF-1] <= i_wb.data[0:HALF-1];
				end
				PPP_LO: begin
					rf_mem[i_wb.rd][HALF:XLEN-1] <= i_wb.data[HALF:XLEN-1];
				end
				default: begin
					// PPP_ALL and the unsupported codes
					rf_mem[i_wb.rd] <= i_wb.data;
				end
			endcase
		end
	end

endmodule

/* verilog/exec_stage.sv */
module exec_stage import cardinal_pkg::*; (
	input  logic            CLK,
	input  logic            RST,
	input  dec_t            i_dec,
	input  word_t           i_rs1,
	input  word_t           i_rs2,
	input  word_t           i_data_in,
	output logic            o_mem_en,
	output logic            o_mem_wr_en,
	output logic [0:ILEN-1] o_mem_addr,
	output word_t           o_data_out,
	output wb_t             o_wb
);

	localparam dec_t DEC_NOP = '{opcode: OP_NOP, default: '0};

	// write-back control
	typedef struct packed {
		logic      we;
		logic      load;    // take memory data instead of alu result
		reg_addr_t rd;
		ppp_t      ppp;
	} wb_ctl_t;

	dec_t    ex_dec;
	word_t   ex_rs1;
	word_t   ex_rs2;
	word_t   alu_y;
	logic    is_alu;
	logic    is_load;
	logic    is_store;
	wb_ctl_t wb_ctl;
	word_t   wb_alu;
	word_t   wb_mem;

	// ------------------------------------------------------------------------
	// execute register
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			ex_dec <= DEC_NOP;
		end else begin
			ex_dec <= i_dec;
		end
	end

	always_ff @(posedge CLK) begin
		ex_rs1 <= i_rs1;
		ex_rs2 <= i_rs2;
	end

	assign is_alu   = (ex_dec.opcode == OP_ALU);
	assign is_load  = (ex_dec.opcode == OP_LOAD);
	assign is_store = (ex_dec.opcode == OP_STORE);

	// memory side, valid in the execute cycle
	assign o_mem_en    = is_load | is_store;
	assign o_mem_wr_en = is_store;
	assign o_mem_addr  = {{(ILEN-IMM_W){1'b0}}, ex_dec.imm};    // imm is zero unless ld/st
	assign o_data_out  = ex_rs1;

	simd_alu alu0 (
		.i_func (ex_dec.func),
		.i_ww   (ex_dec.ww),
		.i_a    (ex_rs1),
		.i_b    (ex_rs2),
		.o_y    (alu_y)
	);

	// ------------------------------------------------------------------------
	// write-back register
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			wb_ctl <= '0;
		end else begin
			wb_ctl.we   <= is_alu | is_load;
			wb_ctl.load <= is_load;
			wb_ctl.rd   <= ex_dec.rd;
			wb_ctl.ppp  <= is_load ? PPP_ALL : ex_dec.ppp;    // loads write whole word
		end
	end

	always_ff @(posedge CLK) begin
		wb_alu <= alu_y;
		wb_mem <= i_data_in;
	end

	assign o_wb = '{
		we:   wb_ctl.we,
		rd:   wb_ctl.rd,
		ppp:  wb_ctl.ppp,
		data: wb_ctl.load ? wb_mem : wb_alu
	};

endmodule

/* verilog/cardinal_core.sv */
module cardinal_core import cardinal_pkg::*; (
	input  logic            CLK,
	input  logic            RST,
	input  logic [0:ILEN-1] i_instruction,    // word at o_pc
	input  word_t           i_data_in,        // read data for o_mem_addr
	output logic [0:ILEN-1] o_pc,
	output word_t           o_data_out,
	output logic [0:ILEN-1] o_mem_addr,
	output logic            o_mem_en,
	output logic            o_mem_wr_en
);

	dec_t  dec;
	word_t rs1;
	word_t rs2;
	wb_t   wb;

	// fetch/decode -> register read -> execute/memory -> write-back
	fetch_decode fd0 (
		.i_clk         (CLK),
		.i_rst         (RST),
		.i_instruction (i_instruction),
		.o_pc          (o_pc),
		.o_dec         (dec)
	);

	reg_file rf0 (
		.CLK   (CLK),
		.RST   (RST),
		.i_ra  (dec.ra),
		.i_rb  (dec.rb),
		.i_wb  (wb),
		.o_rs1 (rs1),
		.o_rs2 (rs2)
	);

	exec_stage ex0 (
		.CLK         (CLK),
		.RST         (RST),
		.i_dec       (dec),
		.i_rs1       (rs1),
		.i_rs2       (rs2),
		.i_data_in   (i_data_in),
		.o_mem_en    (o_mem_en),
		.o_mem_wr_en (o_mem_wr_en),
		.o_mem_addr  (o_mem_addr),
		.o_data_out  (o_data_out),
		.o_wb        (wb)
	);

endmodule

/* tb/cardinal_core_checker.sv */
module cardinal_core_checker import cardinal_pkg::*; (
	input logic            CLK,
	input logic            RST,
	input logic [0:ILEN-1] i_pc,
	input logic [0:ILEN-1] i_mem_addr,
	input logic            i_mem_en,
	input logic            i_mem_wr_en
);

	timeunit 1ns;
	timeprecision 1ps;

	// a store always comes with the memory enable
	a_wr_has_en: assert property (@(posedge CLK) i_mem_wr_en |-> i_mem_en)
		else $error("store strobe without memory enable");

	// execute holds a nop through reset and the cycle after
	a_quiet_reset: assert property (@(posedge CLK) RST |=> !i_mem_en && !i_mem_wr_en)
		else $error("memory strobe during or right after reset");

	// ------------------------------------------------------------------------
	// program counter
	// ------------------------------------------------------------------------
	a_pc_step: assert property (@(posedge CLK) disable iff (RST)
		!$past(RST) |-> i_pc == $past(i_pc) + PC_STEP)
		else $error("program counter did not advance by one step");

	// address is the zero-extended immediate
	a_addr_zext: assert property (@(posedge CLK)
		i_mem_en |-> i_mem_addr[0:ILEN-IMM_W-1] == '0)
		else $error("upper memory address bits are set");

endmodule

bind cardinal_core cardinal_core_checker chk0 (
	.CLK         (CLK),
	.RST         (RST),
	.i_pc        (o_pc),
	.i_mem_addr  (o_mem_addr),
	.i_mem_en    (o_mem_en),
	.i_mem_wr_en (o_mem_wr_en)
);

/* tb/cardinal_core_tb.sv */
module cardinal_core_tb import cardinal_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DRAIN_LIMIT = 200;    // cycles
	localparam int RESET_LIMIT = 20;
	localparam int N_RANDOM    = 120;

	localparam logic [5:0] FN_LIST [11] = '{FN_AND, FN_OR, FN_XOR, FN_NOT, FN_MOV,
		FN_ADD, FN_SUB, FN_SWAP, FN_SLL, FN_SRL, FN_SRA};

	// one expected memory access
	typedef struct packed {
		logic [15:0] addr;
		logic        wr;
		logic [63:0] data;    // store data only
	} access_t;

	logic        CLK;
	logic        RST;
	logic [31:0] instr;
	logic [63:0] data_in;
	logic [31:0] pc;
	logic [63:0] data_out;
	logic [31:0] mem_addr;
	logic        mem_en;
	logic        mem_wr_en;

	logic [31:0] prog [$];
	access_t     exp_q [$];
	logic [63:0] ref_regs [32];
	int          last_wr [32];    // slot of the latest writer
	logic [31:0] lcg_state = 32'h282;
	int          val_err = 0;
	int          seq_err = 0;
	int          to_err = 0;
	int          n_access = 0;

	cardinal_core dut0 (
		.CLK           (CLK),
		.RST           (RST),
		.i_instruction (instr),
		.i_data_in     (data_in),
		.o_pc          (pc),
		.o_data_out    (data_out),
		.o_mem_addr    (mem_addr),
		.o_mem_en      (mem_en),
		.o_mem_wr_en   (mem_wr_en)
	);

	assign data_in = mem_fill(mem_addr[15:0]);    // read-only data memory

	initial begin
		CLK = 1'b0;
		forever begin
			#4 CLK = ~CLK;
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [63:0] mem_fill(input logic [15:0] a);
		return {a ^ 16'hc3a5, ~a, a * 16'd13 + 16'h01f7, {a[7:0], a[15:8]}};
	endfunction

	// expected alu result, lanes handled one at a time
	function automatic logic [63:0] alu_ref(input logic [5:0] func, input logic [1:0] ww,
		input logic [63:0] a, input logic [63:0] b);
		int          w;
		int          k;
		int          sh;
		logic [63:0] mask;
		logic [63:0] la;
		logic [63:0] lb;
		logic [63:0] lr;
		logic [63:0] y;
		w    = 8 << ww;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		y    = '0;
		case (func)
			FN_AND: y = a & b;
			FN_OR:  y = a | b;
			FN_XOR: y = a ^ b;
			FN_NOT: y = ~a;
			FN_MOV: y = a;
			FN_ADD, FN_SUB, FN_SWAP, FN_SLL, FN_SRL, FN_SRA: begin
				for (k = 0; k < 64 / w; k++) begin
					la = (a >> (k * w)) & mask;
					lb = (b >> (k * w)) & mask;
					sh = int'(lb[5:0]) % w;    // low log2(w) bits
					case (func)
						FN_ADD:  lr = la + lb;
						FN_SUB:  lr = la - lb;
						FN_SWAP: lr = (la >> (w / 2)) | (la << (w / 2));
						FN_SLL:  lr = la << sh;
						FN_SRL:  lr = la >> sh;
						default: begin
							lr = la >> sh;
							if (la[w-1]) begin
								lr = lr | ~(mask >> sh);    // copy the sign in
							end
						end
					endcase
					y = y | ((lr & mask) << (k * w));
				end
			end
			default: y = '0;
		endcase
		return y;
	endfunction

	function automatic logic [31:0] enc_alu(input logic [5:0] func, input logic [1:0] ww,
		input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb,
		input logic [2:0] ppp);
		return {OP_ALU, rd, ra, rb, ppp, ww, func};
	endfunction

	function automatic logic [31:0] enc_mem(input logic [5:0] op, input logic [4:0] r,
		input logic [15:0] imm);
		return {op, r, 5'd0, imm};
	endfunction

	// ------------------------------------------------------------------------
	// program generator and register model
	// ------------------------------------------------------------------------
	task automatic model_write(input logic [4:0] rd, input logic [2:0] ppp,
		input logic [63:0] d);
		if (rd != 5'd0) begin
			case (ppp)
				PPP_HI:  ref_regs[rd][63:32] = d[63:32];    // leftmost half
				PPP_LO:  ref_regs[rd][31:0] = d[31:0];
				default: ref_regs[rd] = d;
			endcase
		end
	endtask

	// fill with nops and unknown opcodes up to a slot
	task automatic pad_to(input int slot);
		logic [31:0] r;
		logic [5:0]  op;
		while (prog.size() < slot) begin
			r  = next_rand();
			op = r[31:26];
			if (op == OP_ALU || op == OP_LOAD || op == OP_STORE) begin
				op = OP_NOP;
			end
			prog.push_back({op, r[25:0]});
		end
	endtask

	task automatic gen_load(input logic [4:0] rd, input logic [15:0] addr);
		access_t acc;
		acc = '{addr: addr, wr: 1'b0, data: 64'd0};
		last_wr[rd] = prog.size();
		prog.push_back(enc_mem(OP_LOAD, rd, addr));
		exp_q.push_back(acc);
		model_write(rd, PPP_ALL, mem_fill(addr));
	endtask

	task automatic gen_store(input logic [4:0] rs, input logic [15:0] addr);
		access_t acc;
		pad_to(last_wr[rs] + 3);
		acc = '{addr: addr, wr: 1'b1, data: ref_regs[rs]};
		prog.push_back(enc_mem(OP_STORE, rs, addr));
		exp_q.push_back(acc);
	endtask

	task automatic gen_alu(input logic [5:0] func, input logic [1:0] ww, input logic [4:0] rd,
		input logic [4:0] ra, input logic [4:0] rb, input logic [2:0] ppp);
		logic [63:0] y;
		pad_to(last_wr[ra] + 3);
		pad_to(last_wr[rb] + 3);
		y = alu_ref(func, ww, ref_regs[ra], ref_regs[rb]);
		last_wr[rd] = prog.size();
		prog.push_back(enc_alu(func, ww, rd, ra, rb, ppp));
		model_write(rd, ppp, y);
	endtask

	task automatic build_program();
		int          i;
		int          k;
		logic [31:0] r;
		logic [31:0] s;
		logic [5:0]  func;
		for (i = 1; i < 32; i++) begin
			gen_load(5'(i), 16'h0100 + 16'(i * 8));
		end
		gen_load(5'd0, 16'h0040);
		gen_load(5'd7, 16'h0048);     // reloaded right before its store
		gen_store(5'd7, 16'h2000);    // loaded word comes back out 3 slots later
		gen_store(5'd0, 16'h2008);
		gen_alu(FN_NOT, 2'd0, 5'd9, 5'd3, 5'd3, PPP_HI);
		gen_store(5'd9, 16'h2010);
		gen_alu(FN_XOR, 2'd0, 5'd10, 5'd4, 5'd5, PPP_LO);
		gen_store(5'd10, 16'h2018);
		gen_alu(FN_MOV, 2'd0, 5'd0, 5'd6, 5'd6, PPP_ALL);
		gen_store(5'd0, 16'h2020);
		for (i = 0; i < N_RANDOM; i++) begin
			r    = next_rand();
			s    = next_rand();
			k    = int'(s[15:8]) % 13;
			func = (k < 11) ? FN_LIST[k] : s[29:24];    // now and then an unsupported code
			gen_alu(func, r[27:26], r[12:8], r[17:13], r[22:18], r[25:23]);
			gen_store(r[12:8], 16'h3000 + 16'(i * 8));
			if (i % 8 == 7) begin
				gen_load(s[4:0], s[23:8]);
			end
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(posedge CLK);
			n++;
		end
		if (exp_q.size() != 0) begin
			to_err++;
			$display("timeout: %0d expected memory accesses never showed up", exp_q.size());
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		int i;
		RST   = 1'b1;
		instr = '0;
		for (i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
			last_wr[i]  = -3;
		end
		build_program();
		repeat (3) @(posedge CLK);
		RST <= 1'b0;
		foreach (prog[p]) begin
			@(posedge CLK);
			instr <= prog[p];
		end
		@(posedge CLK);
		instr <= {OP_NOP, 26'd0};
		wait_drain();
		repeat (8) @(posedge CLK);    // room for stray accesses
		$display("errors: value %0d, sequence %0d, timeout %0d (memory accesses seen %0d)",
			val_err, seq_err, to_err, n_access);
		if (val_err + seq_err + to_err == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// ------------------------------------------------------------------------
	// checks, sampled on the falling edge
	// ------------------------------------------------------------------------
	initial begin : pc_check
		logic [31:0] exp_pc;
		int          n;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (RST !== 1'b0 && n < RESET_LIMIT);
		assert (RST === 1'b0) else begin
			to_err++;
			$display("reset was never released");
		end
		exp_pc = '0;
		forever begin
			assert (pc == exp_pc) else begin
				val_err++;
				$display("FAILED %0t: pc 0x%h, expected 0x%h", $time, pc, exp_pc);
			end
			exp_pc = exp_pc + 32'd4;
			@(negedge CLK);
		end
	end

	initial begin : compare
		access_t e;
		forever begin
			@(negedge CLK);
			if (!RST) begin
				assert (!mem_wr_en || mem_en) else begin
					seq_err++;
					$display("store strobe without memory enable at %0t", $time);
				end
			end
			if (!RST && mem_en) begin
				n_access++;
				assert (exp_q.size() != 0) else begin
					seq_err++;
					$display("unexpected memory access at %0t, address 0x%h", $time, mem_addr);
				end
				if (exp_q.size() != 0) begin
					e = exp_q.pop_front();
					assert (mem_addr == {16'd0, e.addr}) else begin
						val_err++;
						$display("FAILED %0t: address 0x%h, expected 0x%h", $time, mem_addr,
							e.addr);
					end
					assert (mem_wr_en == e.wr) else begin
						val_err++;
						$display("FAILED %0t: write strobe %b, expected %b", $time, mem_wr_en,
							e.wr);
					end
					if (e.wr) begin
						assert (data_out == e.data) else begin
							val_err++;
							$display("FAILED %0t: store data 0x%h, expected 0x%h", $time,
								data_out, e.data);
						end
					end
				end
			end
		end
	end

endmodule

/* cardinal_core.f */
verilog/cardinal_pkg.sv
verilog/simd_alu.sv
verilog/fetch_decode.sv
verilog/reg_file.sv
verilog/exec_stage.sv
verilog/cardinal_core.sv
tb/cardinal_core_checker.sv
tb/cardinal_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = cardinal_core_tb
FILELIST  = cardinal_core.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
